/* Makefile */
BIN := obj_dir/Vtb_mem_subsystem
SRCS := $(wildcard logic/*.sv tb/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): verilog.f $(SRCS)
	verilator --binary --timing --assert -f verilog.f --top-module tb_mem_subsystem -Mdir obj_dir

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

/* logic/bus_pkg.sv */
package bus_pkg;

  // one data word on every port and on the memory bus.
  typedef logic [31:0] word_t;

  // one enable bit per byte lane.
  typedef logic [3:0] byte_en_t;

  // byte address; the ram only looks at the word index bits.
  typedef logic [31:0] addr_t;

  // byte order of the memory bus as seen from the ports.
  typedef enum logic {
    BIG,
    LITTLE
  } endian_e;

  // instruction fetch request, read only.
  typedef struct packed {
    logic  ren;
    addr_t addr;
  } fetch_req_t;

  // data port request.
  typedef struct packed {
    logic     ren;
    logic     wen;
    addr_t    addr;
    word_t    wdata;
    byte_en_t byte_en;
  } data_req_t;

  // response to either port; busy low for one cycle marks completion.
  typedef struct packed {
    logic  busy;
    word_t rdata;
  } port_rsp_t;

  // memory bus request; req is a one-cycle strobe.
  typedef struct packed {
    logic     req;
    logic     wen;
    addr_t    addr;
    word_t    wdata;
    byte_en_t byte_en;
  } mem_req_t;

  // memory bus response.
  typedef struct packed {
    logic  busy;
    word_t rdata;
  } mem_rsp_t;

endpackage

/* logic/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem #(
  parameter int               WAIT_STATES = 2,
  parameter int               MEM_WORDS   = 256,
  parameter bus_pkg::endian_e BUS_ENDIAN  = bus_pkg::LITTLE
) (
  input  logic                CLK,
  input  logic                nRST,
  input  bus_pkg::fetch_req_t i_fetch,
  input  bus_pkg::data_req_t  i_data,
  output bus_pkg::port_rsp_t  o_fetch_rsp,
  output bus_pkg::port_rsp_t  o_data_rsp
);

  // memory bus between the arbiter and the ram.
  bus_pkg::mem_req_t mem_req;
  bus_pkg::mem_rsp_t mem_rsp;

  // arbiter for the fetch and data ports.
  memory_controller #(
    .BUS_ENDIAN (BUS_ENDIAN)
  ) mc0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_fetch     (i_fetch),
    .i_data      (i_data),
    .o_fetch_rsp (o_fetch_rsp),
    .o_data_rsp  (o_data_rsp),
    .o_mem_req   (mem_req),
    .i_mem_rsp   (mem_rsp)
  );

  // word ram with fixed wait states.
  wait_state_ram #(
    .WAIT_STATES (WAIT_STATES),
    .MEM_WORDS   (MEM_WORDS)
  ) ram0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_mem_req (mem_req),
    .o_mem_rsp (mem_rsp)
  );

endmodule

/* logic/memory_controller.sv */
`timescale 1ns/1ps

module memory_controller #(
  parameter bus_pkg::endian_e BUS_ENDIAN = bus_pkg::LITTLE
) (
  input  logic               CLK,
  input  logic               nRST,
  input  bus_pkg::fetch_req_t i_fetch,
  input  bus_pkg::data_req_t  i_data,
  output bus_pkg::port_rsp_t  o_fetch_rsp,
  output bus_pkg::port_rsp_t  o_data_rsp,
  output bus_pkg::mem_req_t   o_mem_req,
  input  bus_pkg::mem_rsp_t   i_mem_rsp
);

  // arbiter states; the req states issue the bus strobe.
  typedef enum logic [2:0] {
    IDLE,
    INSTR_REQ,
    INSTR_WAIT,
    DATA_REQ,
    DATA_WAIT
  } state_e;

  state_e state_q, state_d;

  // the port that does not own the bus has a request queued.
  logic pend_q, pend_d;

  logic data_req;
  logic fetch_req;
  logic mem_done;
  logic data_own;
  logic fetch_abort;

  bus_pkg::word_t bus_wdata;
  bus_pkg::word_t port_rdata;

  // reverse the four byte lanes of a word.
  function automatic bus_pkg::word_t swap_bytes(input bus_pkg::word_t w);
    swap_bytes = {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // any access on the data port.
  assign data_req  = i_data.ren | i_data.wen;
  assign fetch_req = i_fetch.ren;

  // ram signals the end of a transaction with busy low for one cycle.
  assign mem_done = ~i_mem_rsp.busy;

  // fetch was withdrawn before it reached the bus, e.g. pipeline flush.
  assign fetch_abort = (state_q == INSTR_REQ) & ~fetch_req;

  // data port drives the bus fields in its own states.
  assign data_own = (state_q == DATA_REQ) | (state_q == DATA_WAIT);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q <= IDLE;
      pend_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      pend_q  <= pend_d;
    end
  end

  // next state.
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // data wins when both ask in the same cycle.
        if (data_req) begin
          state_d = DATA_REQ;
        end else if (fetch_req) begin
          state_d = INSTR_REQ;
        end
      end
      INSTR_REQ: begin
        // an aborted fetch never touches the bus.
        if (fetch_abort) begin
          state_d = data_req ? DATA_REQ : IDLE;
        end else begin
          state_d = INSTR_WAIT;
        end
      end
      INSTR_WAIT: begin
        if (mem_done) begin
          state_d = (pend_q | data_req) ? DATA_REQ : IDLE;
        end
      end
      DATA_REQ: begin
        state_d = DATA_WAIT;
      end
      DATA_WAIT: begin
        // a dropped fetch is caught again in INSTR_REQ.
        if (mem_done) begin
          state_d = (pend_q | fetch_req) ? INSTR_REQ : IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // pending follows the other port's request while one port owns the bus.
  // a withdrawn fetch clears it again.
  always_comb begin
    case (state_d)
      DATA_REQ, DATA_WAIT:   pend_d = fetch_req;
      INSTR_REQ, INSTR_WAIT: pend_d = data_req;
      default:               pend_d = 1'b0;
    endcase
  end

  // write data toward the bus, swapped for a little endian bus.
  assign bus_wdata = (BUS_ENDIAN == bus_pkg::LITTLE) ? swap_bytes(i_data.wdata)
                                                     : i_data.wdata;

  // read data toward both ports, same swap rule.
  assign port_rdata = (BUS_ENDIAN == bus_pkg::LITTLE) ? swap_bytes(i_mem_rsp.rdata)
                                                      : i_mem_rsp.rdata;

  // strobe for one cycle in a req state.
  assign o_mem_req.req     = (state_q == DATA_REQ) |
                             ((state_q == INSTR_REQ) & fetch_req);
  assign o_mem_req.wen     = data_own & i_data.wen;
  assign o_mem_req.addr    = data_own ? i_data.addr : i_fetch.addr;
  assign o_mem_req.wdata   = bus_wdata;
  // fetches read the whole word.
  assign o_mem_req.byte_en = data_own ? i_data.byte_en : 4'hf;

  // completion reaches the owning port in the same cycle.
  assign o_fetch_rsp.busy  = ~((state_q == INSTR_WAIT) & mem_done);
  assign o_fetch_rsp.rdata = port_rdata;
  assign o_data_rsp.busy   = ~((state_q == DATA_WAIT) & mem_done);
  assign o_data_rsp.rdata  = port_rdata;

endmodule

/* logic/wait_state_ram.sv */
`timescale 1ns/1ps

module wait_state_ram #(
  parameter int WAIT_STATES = 2,
  parameter int MEM_WORDS   = 256
) (
  input  logic              CLK,
  input  logic              nRST,
  input  bus_pkg::mem_req_t i_mem_req,
  output bus_pkg::mem_rsp_t o_mem_rsp
);

  // word index taken from the byte address.
  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  // counter wide enough to hold WAIT_STATES.
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  bus_pkg::word_t mem [MEM_WORDS];

  // transaction fields latched on the req strobe.
  logic [IDX_W-1:0]  idx_q;
  bus_pkg::word_t    wdata_q;
  bus_pkg::byte_en_t byte_en_q;

  // control state.
  logic             active_q;
  logic             wr_pend_q;
  logic [CNT_W-1:0] cnt_q;

  logic done;

  // last cycle of a transaction.
  assign done = active_q & (cnt_q == '0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      active_q  <= 1'b0;
      wr_pend_q <= 1'b0;
      cnt_q     <= '0;
    end else if (i_mem_req.req) begin
      active_q  <= 1'b1;
      wr_pend_q <= i_mem_req.wen;
      cnt_q     <= CNT_W'(WAIT_STATES);
    end else begin
      // write lands in the first cycle after the strobe.
      wr_pend_q <= 1'b0;
      if (done) begin
        active_q <= 1'b0;
      end else if (active_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (i_mem_req.req) begin
      idx_q     <= i_mem_req.addr[IDX_W+1:2];
      wdata_q   <= i_mem_req.wdata;
      byte_en_q <= i_mem_req.byte_en;
    end
  end

  // byte-lane write.
  always_ff @(posedge CLK) begin
    if (wr_pend_q) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_en_q[i]) begin
          mem[idx_q][8*i +: 8] <= wdata_q[8*i +: 8];
        end
      end
    end
  end

  // busy stays high while idle, low only on completion.
  assign o_mem_rsp.busy  = ~done;
  assign o_mem_rsp.rdata = mem[idx_q];

endmodule

/* tb/mem_subsystem_checker.sv */
`timescale 1ns/1ps

module mem_subsystem_checker (
  input logic               CLK,
  input logic               nRST,
  input bus_pkg::mem_req_t  i_mem_req,
  input bus_pkg::mem_rsp_t  i_mem_rsp,
  input bus_pkg::port_rsp_t i_fetch_rsp,
  input bus_pkg::port_rsp_t i_data_rsp
);

  // a bus transaction is open from the strobe until busy goes low.
  logic open_q;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      open_q <= 1'b0;
    end else if (i_mem_req.req) begin
      open_q <= 1'b1;
    end else if (!i_mem_rsp.busy) begin
      open_q <= 1'b0;
    end
  end

  // strobe is a single cycle.
  a_req_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    i_mem_req.req |=> !i_mem_req.req)
    else $error("memory bus strobe held for two cycles");

  // each ram completion reaches exactly one port, and only then.
  a_one_done: assert property (@(posedge CLK) disable iff (!nRST)
    (!i_fetch_rsp.busy || !i_data_rsp.busy || !i_mem_rsp.busy) |->
      (!i_mem_rsp.busy && (i_fetch_rsp.busy != i_data_rsp.busy)))
    else $error("ram completion not delivered to exactly one port");

  // no new strobe before the ram has finished.
  a_no_overlap: assert property (@(posedge CLK) disable iff (!nRST)
    i_mem_req.req |-> !open_q)
    else $error("memory bus strobe while a transaction is open");

endmodule

// attach to every arbiter instance.
bind memory_controller mem_subsystem_checker chk0 (
  .CLK         (CLK),
  .nRST        (nRST),
  .i_mem_req   (o_mem_req),
  .i_mem_rsp   (i_mem_rsp),
  .i_fetch_rsp (o_fetch_rsp),
  .i_data_rsp  (o_data_rsp)
);

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int RESET_CYCLES = 10
) (
  output logic CLK,
  output logic nRST
);

  // 8 ns period.
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // reset held low for a fixed number of rising edges.
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 nRST = 1'b1;
  end

endmodule

/* tb/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;

  localparam int WAIT_STATES    = 2;
  localparam int MEM_WORDS      = 256;
  localparam int SINGLE_LAT     = WAIT_STATES + 2;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RAND_WORDS     = 16;
  localparam int RAND_OPS       = 40;

  logic CLK;
  logic nRST;

  bus_pkg::fetch_req_t fetch;
  bus_pkg::data_req_t  data;
  bus_pkg::port_rsp_t  fetch_rsp;
  bus_pkg::port_rsp_t  data_rsp;

  // reference memory in bus byte order.
  bus_pkg::word_t ref_mem [MEM_WORDS];

  logic [31:0] lcg_state;
  int          cyc = 0;
  int          fetch_done_cnt = 0;

  tb_clock clk0 (
    .CLK  (CLK),
    .nRST (nRST)
  );

  mem_subsystem #(
    .WAIT_STATES (WAIT_STATES),
    .MEM_WORDS   (MEM_WORDS),
    .BUS_ENDIAN  (bus_pkg::LITTLE)
  ) dut0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_fetch     (fetch),
    .i_data      (data),
    .o_fetch_rsp (fetch_rsp),
    .o_data_rsp  (data_rsp)
  );

  // cycle count, also the run limit.
  always @(posedge CLK) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // every fetch completion seen on the port.
  always @(negedge CLK) begin
    if (nRST && !fetch_rsp.busy) begin
      fetch_done_cnt <= fetch_done_cnt + 1;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // word aligned address inside the first RAND_WORDS words.
  function automatic bus_pkg::addr_t rand_addr();
    logic [31:0] r;
    r = lcg_next();
    return {26'd0, r[21:18], 2'b00};
  endfunction

  // byte lane i of the result is lane 3-i of the input.
  function automatic bus_pkg::word_t reverse_lanes(input bus_pkg::word_t w);
    bus_pkg::word_t r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = w[8*(3-i) +: 8];
    end
    return r;
  endfunction

  // store swapped data under the byte enables.
  task automatic model_write(input bus_pkg::addr_t addr, input bus_pkg::word_t wdata,
                             input bus_pkg::byte_en_t be);
    bus_pkg::word_t sw;
    sw = reverse_lanes(wdata);
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        ref_mem[addr[9:2]][8*i +: 8] = sw[8*i +: 8];
      end
    end
  endtask

  function automatic bus_pkg::word_t model_read(input bus_pkg::addr_t addr);
    return reverse_lanes(ref_mem[addr[9:2]]);
  endfunction

  task automatic check_word(input string what, input bus_pkg::word_t got,
                            input bus_pkg::word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic check_latency(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("** Error at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // sampled mid-cycle, where the outputs are settled.
  task automatic wait_data_done(output bus_pkg::word_t rdata);
    @(negedge CLK);
    while (data_rsp.busy) @(negedge CLK);
    rdata = data_rsp.rdata;
  endtask

  task automatic wait_fetch_done(output bus_pkg::word_t rdata);
    @(negedge CLK);
    while (fetch_rsp.busy) @(negedge CLK);
    rdata = fetch_rsp.rdata;
  endtask

  task automatic data_access(input logic wen, input bus_pkg::addr_t addr,
                             input bus_pkg::word_t wdata, input bus_pkg::byte_en_t be,
                             output bus_pkg::word_t rdata, output int lat);
    int start;
    @(posedge CLK);
    #1;
    data.ren     = ~wen;
    data.wen     = wen;
    data.addr    = addr;
    data.wdata   = wdata;
    data.byte_en = be;
    start = cyc;
    wait_data_done(rdata);
    lat = cyc - start;
    @(posedge CLK);
    #1;
    data = '0;
  endtask

  task automatic data_write_checked(input bus_pkg::addr_t addr, input bus_pkg::word_t wdata,
                                    input bus_pkg::byte_en_t be);
    bus_pkg::word_t rd;
    int lat;
    data_access(1'b1, addr, wdata, be, rd, lat);
    model_write(addr, wdata, be);
    check_latency("data write latency", lat, SINGLE_LAT);
  endtask

  task automatic data_read_checked(input bus_pkg::addr_t addr);
    bus_pkg::word_t rd;
    int lat;
    data_access(1'b0, addr, '0, 4'hf, rd, lat);
    check_word("data read", rd, model_read(addr));
    check_latency("data read latency", lat, SINGLE_LAT);
  endtask

  task automatic fetch_read_checked(input bus_pkg::addr_t addr);
    bus_pkg::word_t rd;
    int start;
    @(posedge CLK);
    #1;
    fetch.ren  = 1'b1;
    fetch.addr = addr;
    start = cyc;
    wait_fetch_done(rd);
    check_word("fetch read", rd, model_read(addr));
    check_latency("fetch read latency", cyc - start, SINGLE_LAT);
    @(posedge CLK);
    #1;
    fetch = '0;
  endtask

  task automatic test_write_read();
    bus_pkg::addr_t a;
    a = rand_addr();
    data_write_checked(a, lcg_next(), 4'hf);
    data_read_checked(a);
  endtask

  // one byte lane at a time over a full word.
  task automatic test_partial_writes();
    bus_pkg::addr_t a;
    a = rand_addr();
    data_write_checked(a, lcg_next(), 4'hf);
    for (int i = 0; i < 4; i++) begin
      data_write_checked(a, lcg_next(), bus_pkg::byte_en_t'(1 << i));
      data_read_checked(a);
    end
  endtask

  task automatic test_fetch_reads();
    bus_pkg::addr_t a;
    for (int i = 0; i < 4; i++) begin
      a = rand_addr();
      data_write_checked(a, lcg_next(), 4'hf);
      fetch_read_checked(a);
    end
  endtask

  // data wins, fetch follows one full transaction later.
  task automatic test_same_cycle();
    bus_pkg::addr_t af;
    bus_pkg::addr_t ad;
    bus_pkg::word_t wd;
    bus_pkg::word_t drd;
    bus_pkg::word_t frd;
    bus_pkg::word_t fexp;
    int start;
    int d_done;
    int f_done;
    af = rand_addr();
    ad = af ^ 32'h4;
    wd = lcg_next();
    data_write_checked(af, lcg_next(), 4'hf);
    fexp = model_read(af);
    @(posedge CLK);
    #1;
    data.wen     = 1'b1;
    data.addr    = ad;
    data.wdata   = wd;
    data.byte_en = 4'hf;
    fetch.ren    = 1'b1;
    fetch.addr   = af;
    start = cyc;
    fork
      begin
        wait_data_done(drd);
        d_done = cyc;
        @(posedge CLK);
        #1;
        data = '0;
      end
      begin
        wait_fetch_done(frd);
        f_done = cyc;
        @(posedge CLK);
        #1;
        fetch = '0;
      end
    join
    model_write(ad, wd, 4'hf);
    check_latency("data latency with both requesting", d_done - start, SINGLE_LAT);
    check_latency("fetch delay after data", f_done - d_done, SINGLE_LAT);
    check_word("queued fetch read", frd, fexp);
    data_read_checked(ad);
  endtask

  // fetch raised and withdrawn while data owns the bus.
  task automatic test_fetch_abort();
    bus_pkg::addr_t a;
    bus_pkg::word_t wd;
    bus_pkg::word_t rd;
    int start;
    int cnt0;
    a = rand_addr();
    wd = lcg_next();
    cnt0 = fetch_done_cnt;
    @(posedge CLK);
    #1;
    data.wen     = 1'b1;
    data.addr    = a;
    data.wdata   = wd;
    data.byte_en = 4'hf;
    start = cyc;
    @(posedge CLK);
    #1;
    fetch.ren  = 1'b1;
    fetch.addr = a ^ 32'h8;
    @(posedge CLK);
    #1;
    fetch = '0;
    wait_data_done(rd);
    check_latency("data latency around aborted fetch", cyc - start, SINGLE_LAT);
    @(posedge CLK);
    #1;
    data = '0;
    model_write(a, wd, 4'hf);
    // a hidden bus access would stretch this one.
    data_read_checked(a);
    repeat (4) @(posedge CLK);
    check_latency("fetch completions after abort", fetch_done_cnt - cnt0, 0);
  endtask

  task automatic test_random_mix();
    logic [31:0] r;
    bus_pkg::addr_t a;
    for (int i = 0; i < RAND_WORDS; i++) begin
      data_write_checked(bus_pkg::addr_t'(i * 4), lcg_next(), 4'hf);
    end
    for (int i = 0; i < RAND_OPS; i++) begin
      r = lcg_next();
      a = rand_addr();
      case (r[31:30])
        2'd0:    fetch_read_checked(a);
        2'd1:    data_read_checked(a);
        2'd2:    data_write_checked(a, lcg_next(), 4'hf);
        default: data_write_checked(a, lcg_next(), r[13:10]);
      endcase
    end
  endtask

  initial begin
    fetch     = '0;
    data      = '0;
    lcg_state = 32'h7d060730;
    @(posedge nRST);
    test_write_read();
    test_partial_writes();
    test_fetch_reads();
    test_same_cycle();
    test_fetch_abort();
    test_random_mix();
    $display("TEST PASS");
    $finish;
  end

endmodule

/* verilog.f */
logic/bus_pkg.sv
logic/memory_controller.sv
logic/wait_state_ram.sv
logic/mem_subsystem.sv
tb/tb_clock.sv
tb/mem_subsystem_checker.sv
tb/tb_mem_subsystem.sv
